//--- common/pokey_io_settings.svh
`ifndef POKEY_IO_SETTINGS_SVH
`define POKEY_IO_SETTINGS_SVH

// last line count of a paddle scan
`define POT_LINES 228

// paddle channels
`define NUM_POTS 8

// keys in the scanned matrix
`define NUM_KEYS 16

`endif

//--- common/pokey_io_types_pkg.sv
`default_nettype none

`include "pokey_io_settings.svh"

package pokey_io_types_pkg;

    // key number, doubles as the matrix select value
    typedef logic [$clog2(`NUM_KEYS)-1:0] key_code_t;

    // line count or latched paddle value
    typedef logic [7:0] pot_count_t;

    typedef logic [`NUM_POTS-1:0] pot_mask_t; // one bit per paddle channel

    // cpu data byte
    typedef logic [7:0] data_t;

    // debounce machine
    typedef enum logic [1:0] {
        IDLE    = 2'd0, // waiting for any key
        CONFIRM = 2'd1, // seen once, wait for next visit of same code
        HELD    = 2'd2  // reported, wait for release
    } key_state_t;

endpackage

`default_nettype wire

//--- common/pokey_io_regmap_pkg.sv
`default_nettype none

package pokey_io_regmap_pkg;

    // cpu register address, low nibble of the chip select range
    typedef logic [3:0] reg_addr_t;

    // pot channel n reads at POT0_ADDR + n
    localparam reg_addr_t POT0_ADDR = 4'd0;

    // capture status, bit set while channel still counting
    localparam reg_addr_t ALLPOT_ADDR = 4'd8;

    localparam reg_addr_t KBCODE_ADDR = 4'd9; // last confirmed key

    // write only, starts a paddle scan
    localparam reg_addr_t POTGO_ADDR = 4'd11;

    // key status, bit 2 low while a key is held
    localparam reg_addr_t SKSTAT_ADDR = 4'd15;

endpackage

`default_nettype wire

//--- common/pot_scan_if.sv
`timescale 1ns/100ps
`default_nettype none

// paddle timer state as seen by the capture latches
interface pot_scan_if;

    pokey_io_types_pkg::pot_count_t line_count; // current line of the scan
    logic scanning;  // level, high between potgo and end of scan
    logic restart;   // one cycle, same edge as potgo
    logic scan_done; // one cycle, edge where count hits the last line

    modport timer (
        output line_count,
        output scanning,
        output restart,
        output scan_done
    );

    modport capture (
        input line_count,
        input scanning,
        input restart,
        input scan_done
    );

endinterface

`default_nettype wire

//--- keyboard/key_scan_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module key_scan_counter (
    input  wire logic                          o2,
    input  wire logic                          rst,
    output pokey_io_types_pkg::key_code_t      scan_code,  // key currently addressed
    output logic [3:0]                         key_scan_l  // matrix select, active low
);

    localparam pokey_io_types_pkg::key_code_t LAST_CODE =
        pokey_io_types_pkg::key_code_t'(`NUM_KEYS - 1);

    // free running, one key per o2 cycle
    always_ff @(posedge o2) begin
        if (rst) begin
            scan_code <= '0;
        end else if (scan_code == LAST_CODE) begin
            scan_code <= '0; // wrap after the last key
        end else begin
            scan_code <= scan_code + 1'b1;
        end
    end

    assign key_scan_l = ~scan_code; // kr1_l answers for this code at the next edge

endmodule

`default_nettype wire

//--- keyboard/key_debounce_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module key_debounce_fsm (
    input  wire logic                          o2,
    input  wire logic                          rst,
    input  wire logic                          kr1_l,     // low, addressed key is down
    input  wire pokey_io_types_pkg::key_code_t scan_code,
    output pokey_io_types_pkg::key_code_t      keycode,   // KBCODE value
    output logic                               key_depr   // key held and reported
);

    pokey_io_types_pkg::key_state_t state_q;
    pokey_io_types_pkg::key_code_t  compare_code; // key under test or held
    logic                           on_compare;   // scan back at the remembered key
    logic                           key_down;

    assign on_compare = (scan_code == compare_code);
    assign key_down   = ~kr1_l;

    // a key must be seen on two visits of its code, 16 cycles apart
    always_ff @(posedge o2) begin
        if (rst) begin
            state_q      <= pokey_io_types_pkg::IDLE;
            compare_code <= '0;
            keycode      <= '0;
        end else begin
            case (state_q)
                pokey_io_types_pkg::IDLE: begin
                    if (key_down) begin
                        compare_code <= scan_code; // remember which key
                        state_q      <= pokey_io_types_pkg::CONFIRM;
                    end
                end

                pokey_io_types_pkg::CONFIRM: begin
                    // other codes in between are don't care
                    if (on_compare) begin
                        if (key_down) begin
                            keycode <= compare_code; // confirmed
                            state_q <= pokey_io_types_pkg::HELD;
                        end else begin
                            state_q <= pokey_io_types_pkg::IDLE; // bounce, drop it
                        end
                    end
                end

                pokey_io_types_pkg::HELD: begin
                    // only the held key matters here
                    if (on_compare && !key_down) begin
                        state_q <= pokey_io_types_pkg::IDLE; // keycode stays latched
                    end
                end

                default: begin
                    state_q <= pokey_io_types_pkg::IDLE;
                end
            endcase
        end
    end

    // high for exactly the time the key is reported
    assign key_depr = (state_q == pokey_io_types_pkg::HELD);

endmodule

`default_nettype wire

//--- pot/pot_line_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module pot_line_timer (
    input  wire logic o2,
    input  wire logic rst,
    input  wire logic potgo,     // write strobe decoded this cycle
    output logic      pot_dump,  // capacitor dump transistors on
    pot_scan_if.timer bus
);

    localparam pokey_io_types_pkg::pot_count_t LAST_LINE =
        pokey_io_types_pkg::pot_count_t'(`POT_LINES);

    pokey_io_types_pkg::pot_count_t line_q;
    logic                           scanning_q;
    logic                           last_line;

    // one count per o2 here, a real chip steps once per tv line
    assign last_line = scanning_q && (line_q == LAST_LINE);

    always_ff @(posedge o2) begin
        if (rst) begin
            line_q     <= '0;
            scanning_q <= 1'b0;
            pot_dump   <= 1'b1; // caps held discharged until first potgo
        end else if (potgo) begin
            line_q     <= '0;   // also restarts a running scan
            scanning_q <= 1'b1;
            pot_dump   <= 1'b0; // let the caps charge
        end else if (last_line) begin
            scanning_q <= 1'b0;
            pot_dump   <= 1'b1;
        end else if (scanning_q) begin
            line_q <= line_q + 1'b1;
        end
    end

    assign bus.line_count = line_q;
    assign bus.scanning   = scanning_q;
    assign bus.restart    = potgo;                // same edge the timer clears
    assign bus.scan_done  = last_line && !potgo;  // potgo wins over end of scan

endmodule

`default_nettype wire

//--- pot/pot_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module pot_capture (
    input  wire logic                          o2,
    input  wire logic                          rst,
    input  wire pokey_io_types_pkg::pot_mask_t pot_scan, // comparator lines
    pot_scan_if.capture                        bus,
    output pokey_io_types_pkg::pot_count_t     pot_values [`NUM_POTS],
    output pokey_io_types_pkg::pot_mask_t      allpot    // set, channel not captured yet
);

    localparam pokey_io_types_pkg::pot_count_t MAX_COUNT =
        pokey_io_types_pkg::pot_count_t'(`POT_LINES);

    // allpot bits double as the per channel armed flags
    always_ff @(posedge o2) begin
        if (rst) begin
            for (int i = 0; i < `NUM_POTS; i++) begin
                pot_values[i] <= '0;
            end
            allpot <= '0;
        end else if (bus.restart) begin
            for (int i = 0; i < `NUM_POTS; i++) begin
                pot_values[i] <= '0;
            end
            allpot <= '1; // every channel counting again
        end else if (bus.scan_done) begin
            // paddles that never crossed read as full scale
            for (int i = 0; i < `NUM_POTS; i++) begin
                if (allpot[i]) begin
                    pot_values[i] <= MAX_COUNT;
                end
            end
            allpot <= '0;
        end else if (bus.scanning) begin
            for (int i = 0; i < `NUM_POTS; i++) begin
                // first high sample only, later ones ignored
                if (pot_scan[i] && allpot[i]) begin
                    pot_values[i] <= bus.line_count;
                    allpot[i]     <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pokey_io_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module pokey_io_regs (
    input  wire pokey_io_regmap_pkg::reg_addr_t addr_bus,
    input  wire logic                           wr,
    input  wire pokey_io_types_pkg::pot_count_t pot_values [`NUM_POTS],
    input  wire pokey_io_types_pkg::pot_mask_t  allpot,
    input  wire pokey_io_types_pkg::key_code_t  keycode,
    input  wire logic                           key_depr,
    output logic                                potgo,    // start pulse to paddle timer
    output pokey_io_types_pkg::data_t           data_out
);

    pokey_io_types_pkg::data_t skstat;

    // write decode, only potgo is writable here
    assign potgo = wr && (addr_bus == pokey_io_regmap_pkg::POTGO_ADDR);

    // key held pulls bit 2 low, the rest idle high
    assign skstat = {5'b11111, ~key_depr, 2'b11};

    always_comb begin
        if (addr_bus < pokey_io_regmap_pkg::ALLPOT_ADDR) begin
            data_out = pot_values[addr_bus[2:0]]; // POT0..POT7
        end else begin
            case (addr_bus)
                pokey_io_regmap_pkg::ALLPOT_ADDR: data_out = allpot;
                pokey_io_regmap_pkg::KBCODE_ADDR: begin
                    data_out = {4'b0000, keycode}; // upper bits unused
                end
                pokey_io_regmap_pkg::SKSTAT_ADDR: data_out = skstat;
                default:                          data_out = 8'hff; // open bus
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/pokey_io_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module pokey_io_top (
    input  wire logic                           o2,
    input  wire logic                           rst,
    input  wire pokey_io_regmap_pkg::reg_addr_t addr_bus,
    input  wire logic                           wr,
    input  wire pokey_io_types_pkg::pot_mask_t  pot_scan,   // paddle comparators
    input  wire logic                           kr1_l,      // matrix return line
    output logic [3:0]                          key_scan_l,
    output logic                                pot_dump,
    output pokey_io_types_pkg::data_t           data_out
);

    pokey_io_types_pkg::key_code_t  scan_code;
    pokey_io_types_pkg::key_code_t  keycode;
    logic                           key_depr;
    logic                           potgo;
    pokey_io_types_pkg::pot_count_t pot_values [`NUM_POTS];
    pokey_io_types_pkg::pot_mask_t  allpot;

    pot_scan_if pot_bus ();

    // keyboard side
    key_scan_counter u_key_scan (
        .o2         (o2),
        .rst        (rst),
        .scan_code  (scan_code),
        .key_scan_l (key_scan_l)
    );

    key_debounce_fsm u_key_debounce (
        .o2        (o2),
        .rst       (rst),
        .kr1_l     (kr1_l),
        .scan_code (scan_code),
        .keycode   (keycode),
        .key_depr  (key_depr)
    );

    // paddle side
    pot_line_timer u_pot_timer (
        .o2       (o2),
        .rst      (rst),
        .potgo    (potgo),
        .pot_dump (pot_dump),
        .bus      (pot_bus.timer)
    );

    pot_capture u_pot_capture (
        .o2         (o2),
        .rst        (rst),
        .pot_scan   (pot_scan),
        .bus        (pot_bus.capture),
        .pot_values (pot_values),
        .allpot     (allpot)
    );

    // cpu facing decode
    pokey_io_regs u_regs (
        .addr_bus   (addr_bus),
        .wr         (wr),
        .pot_values (pot_values),
        .allpot     (allpot),
        .keycode    (keycode),
        .key_depr   (key_depr),
        .potgo      (potgo),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

//--- sim/pokey_io_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pokey_io_settings.svh"

module pokey_io_tb;

    logic                           o2;
    logic                           rst;
    pokey_io_regmap_pkg::reg_addr_t addr_bus;
    logic                           wr;
    pokey_io_types_pkg::pot_mask_t  pot_scan;   // comparator model output
    logic                           kr1_l;      // matrix model output
    logic [3:0]                     key_scan_l;
    logic                           pot_dump;
    pokey_io_types_pkg::data_t      data_out;

    logic [`NUM_KEYS-1:0]          key_pressed; // keys held down by the test
    pokey_io_types_pkg::key_code_t bounce_key;
    int                            bounce_req;    // bumped to ask for one bounce slot
    int                            bounce_served; // catches up once the slot is driven
    int                            pot_target [`NUM_POTS]; // above 228 never crosses
    int                            edge_cnt;      // edges since the potgo edge or 1000 when idle

    pokey_io_top uut (
        .o2         (o2),
        .rst        (rst),
        .addr_bus   (addr_bus),
        .wr         (wr),
        .pot_scan   (pot_scan),
        .kr1_l      (kr1_l),
        .key_scan_l (key_scan_l),
        .pot_dump   (pot_dump),
        .data_out   (data_out)
    );

    initial begin
        o2 = 1'b0;
        forever #10 o2 = ~o2;
    end

    // potgo edge is count 0 and edge k after it presents line count k-1
    initial begin
        edge_cnt = 1000;
        forever begin
            @(posedge o2);
            if (wr && addr_bus == pokey_io_regmap_pkg::POTGO_ADDR) begin
                edge_cnt = 0;
            end else if (edge_cnt < 1000) begin
                edge_cnt = edge_cnt + 1; // saturates back at idle
            end
        end
    end

    // matrix and paddle models driven on the falling edge
    initial begin
        kr1_l         = 1'b1;
        pot_scan      = '0;
        bounce_served = 0;
        forever begin
            @(negedge o2);
            if (bounce_served != bounce_req && ~key_scan_l == bounce_key) begin
                kr1_l         = 1'b0; // one low sample only
                bounce_served = bounce_req;
            end else begin
                kr1_l = ~key_pressed[~key_scan_l];
            end
            for (int i = 0; i < `NUM_POTS; i++) begin
                // comparator high once the cap has charged past target
                pot_scan[i] = (edge_cnt >= pot_target[i]) && (edge_cnt <= `POT_LINES);
            end
        end
    end

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input pokey_io_types_pkg::data_t actual,
                              input pokey_io_types_pkg::data_t expected);
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected 0x%02h, actual 0x%02h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // one read per cycle with the address set on the falling edge
    task automatic read_reg(input pokey_io_regmap_pkg::reg_addr_t addr,
                            output pokey_io_types_pkg::data_t value);
        @(negedge o2);
        wr       = 1'b0;
        addr_bus = addr;
        #2;
        value = data_out;
    endtask

    task automatic write_potgo();
        @(negedge o2);
        addr_bus = pokey_io_regmap_pkg::POTGO_ADDR;
        wr       = 1'b1; // taken at the next rising edge
    endtask

    task automatic pick_targets(input int low);
        for (int i = 0; i < `NUM_POTS; i++) begin
            if ($urandom_range(3) == 0) begin
                pot_target[i] = `POT_LINES + 12;
            end else begin
                pot_target[i] = low + int'($urandom_range(`POT_LINES - 1 - low));
            end
        end
    endtask

    // channel captured at edge target+1 and scan over at edge 229
    function automatic pokey_io_types_pkg::pot_mask_t expected_allpot();
        pokey_io_types_pkg::pot_mask_t mask;
        for (int i = 0; i < `NUM_POTS; i++) begin
            mask[i] = (edge_cnt <= pot_target[i]) && (edge_cnt <= `POT_LINES);
        end
        return mask;
    endfunction

    function automatic pokey_io_types_pkg::data_t expected_pot(input int ch);
        if (edge_cnt > `POT_LINES) begin
            return (pot_target[ch] < `POT_LINES) ? 8'(pot_target[ch]) : 8'(`POT_LINES);
        end else if (edge_cnt > pot_target[ch]) begin
            return 8'(pot_target[ch]);
        end
        return 8'h00;
    endfunction

    task automatic check_pot_values();
        pokey_io_types_pkg::data_t value;
        for (int i = 0; i < `NUM_POTS; i++) begin
            read_reg(pokey_io_regmap_pkg::POT0_ADDR + 4'(i), value);
            check_byte($sformatf("POT%0d", i), value, expected_pot(i));
        end
    endtask

    task automatic run_scan_to_end();
        pokey_io_types_pkg::data_t value;
        int                        cycles;
        cycles = 0;
        do begin
            read_reg(pokey_io_regmap_pkg::ALLPOT_ADDR, value);
            check_byte("ALLPOT", value, expected_allpot());
            check_byte("pot_dump", {7'b0, pot_dump}, {7'b0, edge_cnt > `POT_LINES});
            cycles++;
        end while (!pot_dump && cycles < 300);
        assert (pot_dump) else begin
            $display("timeout, pot_dump never came back on after potgo");
            stop_with_failure();
        end
        check_pot_values();
    endtask

    task automatic wait_for_reg(input string name, input pokey_io_regmap_pkg::reg_addr_t addr,
                                input pokey_io_types_pkg::data_t mask,
                                input pokey_io_types_pkg::data_t want, input int limit);
        pokey_io_types_pkg::data_t value;
        int                        cycles;
        cycles = 0;
        do begin
            read_reg(addr, value);
            cycles++;
        end while (((value & mask) !== want) && cycles < limit);
        assert ((value & mask) === want) else begin
            $display("timeout, %s did not reach 0x%02h within %0d cycles", name, want, limit);
            stop_with_failure();
        end
    endtask

    initial begin
        pokey_io_types_pkg::data_t     value;
        pokey_io_types_pkg::key_code_t key_a;
        pokey_io_types_pkg::key_code_t key_b;
        void'($urandom(11845));
        rst         = 1'b1;
        wr          = 1'b0;
        addr_bus    = '0;
        key_pressed = '0;
        bounce_key  = '0;
        bounce_req  = 0;
        for (int i = 0; i < `NUM_POTS; i++) begin
            pot_target[i] = 0;
        end
        repeat (3) @(posedge o2);
        @(negedge o2);
        rst = 1'b0;
        #2;
        check_byte("key_scan_l", {4'h0, key_scan_l}, 8'h0f);

        // whole map after reset while the select lines step one code per cycle
        for (int i = 0; i < 16; i++) begin
            read_reg(4'(i), value);
            check_byte($sformatf("data_out at address %0d", i), value,
                       (i <= 9) ? 8'h00 : 8'hff);
            check_byte("key_scan_l", {4'h0, key_scan_l}, {4'h0, ~4'(i + 1)});
            check_byte("pot_dump", {7'b0, pot_dump}, 8'h01);
        end

        pick_targets(0); // plain scan
        write_potgo();
        run_scan_to_end();

        pick_targets(0); // restart partway through
        write_potgo();
        for (int i = 0; i < 100; i++) begin
            read_reg(pokey_io_regmap_pkg::ALLPOT_ADDR, value);
            check_byte("ALLPOT", value, expected_allpot());
        end
        pick_targets(8); // none crosses during the clear checks
        write_potgo();
        read_reg(pokey_io_regmap_pkg::ALLPOT_ADDR, value);
        check_byte("ALLPOT", value, 8'hff);
        for (int i = 0; i < `NUM_POTS; i++) begin
            read_reg(pokey_io_regmap_pkg::POT0_ADDR + 4'(i), value);
            check_byte($sformatf("POT%0d", i), value, 8'h00);
        end
        run_scan_to_end();

        key_a = 4'($urandom_range(15)); // single key press
        key_pressed[key_a] = 1'b1;
        wait_for_reg("SKSTAT bit 2", pokey_io_regmap_pkg::SKSTAT_ADDR, 8'h04, 8'h00, 40);
        read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
        check_byte("KBCODE", value, {4'h0, key_a});
        for (int i = 0; i < 40; i++) begin
            read_reg(pokey_io_regmap_pkg::SKSTAT_ADDR, value);
            check_byte("SKSTAT bit 2", value & 8'h04, 8'h00);
        end
        key_pressed[key_a] = 1'b0;
        wait_for_reg("SKSTAT bit 2", pokey_io_regmap_pkg::SKSTAT_ADDR, 8'h04, 8'h04, 32);
        read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
        check_byte("KBCODE", value, {4'h0, key_a});

        key_b      = key_a + 4'($urandom_range(14) + 1); // bounce on some other key
        bounce_key = key_b;
        bounce_req++;
        for (int i = 0; i < 48; i++) begin
            read_reg(pokey_io_regmap_pkg::SKSTAT_ADDR, value);
            check_byte("SKSTAT bit 2", value & 8'h04, 8'h04);
        end
        assert (bounce_served == bounce_req) else begin
            $display("bounce sample for key %0d was never driven", key_b);
            stop_with_failure();
        end
        read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
        check_byte("KBCODE", value, {4'h0, key_a});

        key_a = 4'($urandom_range(15)); // second key while first is held
        key_b = key_a + 4'($urandom_range(14) + 1);
        key_pressed[key_a] = 1'b1;
        wait_for_reg("SKSTAT bit 2", pokey_io_regmap_pkg::SKSTAT_ADDR, 8'h04, 8'h00, 40);
        read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
        check_byte("KBCODE", value, {4'h0, key_a});
        key_pressed[key_b] = 1'b1;
        for (int i = 0; i < 48; i++) begin
            read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
            check_byte("KBCODE", value, {4'h0, key_a});
        end
        key_pressed[key_a] = 1'b0; // b takes over once a is seen released
        wait_for_reg("KBCODE", pokey_io_regmap_pkg::KBCODE_ADDR, 8'hff, {4'h0, key_b}, 64);
        read_reg(pokey_io_regmap_pkg::SKSTAT_ADDR, value);
        check_byte("SKSTAT bit 2", value & 8'h04, 8'h00);
        key_pressed[key_b] = 1'b0;
        wait_for_reg("SKSTAT bit 2", pokey_io_regmap_pkg::SKSTAT_ADDR, 8'h04, 8'h04, 32);
        read_reg(pokey_io_regmap_pkg::KBCODE_ADDR, value);
        check_byte("KBCODE", value, {4'h0, key_b});

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/pokey_io_types_pkg.sv
common/pokey_io_regmap_pkg.sv
common/pot_scan_if.sv
keyboard/key_scan_counter.sv
keyboard/key_debounce_fsm.sv
pot/pot_line_timer.sv
pot/pot_capture.sv
design/pokey_io_regs.sv
design/pokey_io_top.sv
sim/pokey_io_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= pokey_io_tb
RTL_TOP   ?= pokey_io_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

SOURCES   := $(shell grep -v '^+' $(FILELIST))
RTL_FILES := $(filter-out sim/%,$(SOURCES))
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST) common/pokey_io_settings.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Icommon --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
